// ==== Makefile ====
SIM_BIN = obj_dir/Vstream_src_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove obj_dir"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module stream_src_tb -f list.f
	@out=$$(./$(SIM_BIN)); echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir

// ==== hw/src_addr_gen.sv ====
// ##########################################################################
// source address generator
// holds the current byte address and the beats still to request,
// stepping by the stride on every taken request
// ##########################################################################

`timescale 1ns/1ps

module src_addr_gen
  import stream_src_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              load_i,
  input  logic              step_i,
  input  logic [ADDR_W-1:0] base_addr_i,
  input  logic [CNT_W-1:0]  stride_i,
  input  logic [CNT_W-1:0]  trans_size_i,
  output logic [ADDR_W-1:0] addr_o,
  output logic              last_o
);

  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] stride_q;  // upper stride bits vanish in the wrap
  logic [CNT_W-1:0]  left_q;    // beats not yet requested

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q   <= '0;
      stride_q <= '0;
      left_q   <= '0;
    end else if (clear_i) begin
      addr_q   <= '0;
      stride_q <= '0;
      left_q   <= '0;
    end else if (load_i) begin
      addr_q   <= base_addr_i;
      stride_q <= stride_i[ADDR_W-1:0];
      left_q   <= trans_size_i;
    end else if (step_i) begin
      addr_q <= addr_q + stride_q;  // modulo 4096
      left_q <= left_q - 1'b1;
    end
  end

  assign addr_o = addr_q;
  assign last_o = (left_q == CNT_W'(1));

endmodule

// ==== hw/src_ctrl_fsm.sv ====
// ##########################################################################
// source control FSM
// starts a transfer, issues word reads while the stream can take them
// and pulses done once the last response has left the buffer
// ##########################################################################

`timescale 1ns/1ps

module src_ctrl_fsm
  import stream_src_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic start_i,
  input  logic out_ready_i,
  input  logic held_i,
  input  logic gnt_i,
  input  logic last_i,
  output logic ready_start_o,
  output logic req_o,
  output logic step_o,
  output logic load_o,
  output logic done_o
);

  src_state_e state_q, state_d;
  logic       pending_q;  // response to the last taken req arrives now
  logic       done_q, done_d;
  logic       idle_ready;

  // not ready while the done pulse is still out
  assign idle_ready    = (state_q == SRC_IDLE) && !done_q;
  assign ready_start_o = idle_ready;
  assign load_o        = idle_ready && start_i;

  // one beat in flight at most, so only ask when the buffer is free
  assign req_o  = (state_q == SRC_WORKING) && out_ready_i && !held_i && !clear_i;
  assign step_o = req_o && gnt_i;
  assign done_o = done_q;

  always_comb begin
    state_d = state_q;
    done_d  = 1'b0;
    case (state_q)
      SRC_IDLE: begin
        if (load_o) begin
          state_d = SRC_WORKING;
        end
      end
      SRC_WORKING: begin
        if (step_o && last_i) begin
          state_d = SRC_DRAIN;
        end
      end
      SRC_DRAIN: begin
        if (!pending_q && !held_i) begin  // last beat gone
          done_d  = 1'b1;
          state_d = SRC_IDLE;
        end
      end
      default: state_d = SRC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= SRC_IDLE;
      pending_q <= 1'b0;
      done_q    <= 1'b0;
    end else if (clear_i) begin
      state_q   <= SRC_IDLE;
      pending_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      state_q   <= state_d;
      pending_q <= step_o;
      done_q    <= done_d;
    end
  end

endmodule

// ==== hw/src_resp_buffer.sv ====
// ##########################################################################
// source response buffer
// passes memory responses to the stream and keeps one that the stream
// did not take until it is accepted
// ##########################################################################

`timescale 1ns/1ps

module src_resp_buffer
  import stream_src_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              r_valid_i,
  input  logic [DATA_W-1:0] r_data_i,
  input  logic              out_ready_i,
  output logic              held_o,
  output logic              out_valid_o,
  output logic [DATA_W-1:0] out_data_o
);

  logic              held_q;
  logic [DATA_W-1:0] data_q;

  // r_valid never meets a held beat, the FSM waits for the buffer
  assign out_valid_o = r_valid_i || held_q;
  assign out_data_o  = held_q ? data_q : r_data_i;
  assign held_o      = held_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= 1'b0;
    end else if (clear_i) begin
      held_q <= 1'b0;  // a response in this cycle is lost
    end else if (r_valid_i && !out_ready_i) begin
      held_q <= 1'b1;
    end else if (held_q && out_ready_i) begin
      held_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (r_valid_i && !out_ready_i) begin
      data_q <= r_data_i;
    end
  end

endmodule

// ==== hw/stream_src_pkg.sv ====
// ##########################################################################
// stream source package
// shared widths, scratchpad depth and the source state type for the
// memory-to-stream subsystem
// ##########################################################################

package stream_src_pkg;

  // stream beat and memory word
  localparam int unsigned DATA_W = 32;

  // byte address, wraps modulo 4096
  localparam int unsigned ADDR_W = 12;

  // scratchpad depth in words
  localparam int unsigned MEM_WORDS = 1024;

  // word index bits, the two byte bits below are ignored
  localparam int unsigned MEM_AW = $clog2(MEM_WORDS);

  // beat count and stride
  localparam int unsigned CNT_W = 16;

  typedef enum logic [1:0] {
    SRC_IDLE    = 2'b00,
    SRC_WORKING = 2'b01,
    SRC_DRAIN   = 2'b10
  } src_state_e;

endpackage

// ==== hw/stream_src_top.sv ====
// ##########################################################################
// stream source top
// control FSM, address generator and response buffer reading from
// the local scratchpad over one tcdm port
// ##########################################################################

`timescale 1ns/1ps

module stream_src_top
  import stream_src_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              start_i,
  input  logic [ADDR_W-1:0] base_addr_i,
  input  logic [CNT_W-1:0]  stride_i,
  input  logic [CNT_W-1:0]  trans_size_i,
  input  logic              wr_en_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic [DATA_W-1:0] wr_data_i,
  input  logic              out_ready_i,
  output logic              ready_start_o,
  output logic              done_o,
  output logic              out_valid_o,
  output logic [DATA_W-1:0] out_data_o
);

  tcdm_if mem_bus ();

  logic              src_req;
  logic [ADDR_W-1:0] src_addr;
  logic              step, load, last, held;

  assign mem_bus.req = src_req;
  assign mem_bus.add = src_addr;

  src_ctrl_fsm u_fsm (
    .clk_i, .rst_ni, .clear_i, .start_i, .out_ready_i,
    .held_i        (held),
    .gnt_i         (mem_bus.gnt),
    .last_i        (last),
    .ready_start_o,
    .req_o         (src_req),
    .step_o        (step),
    .load_o        (load),
    .done_o
  );

  src_addr_gen u_addr_gen (
    .clk_i, .rst_ni, .clear_i,
    .load_i (load),
    .step_i (step),
    .base_addr_i, .stride_i, .trans_size_i,
    .addr_o (src_addr),
    .last_o (last)
  );

  src_resp_buffer u_resp_buf (
    .clk_i, .rst_ni, .clear_i,
    .r_valid_i (mem_bus.r_valid),
    .r_data_i  (mem_bus.r_data),
    .out_ready_i,
    .held_o    (held),
    .out_valid_o, .out_data_o
  );

  tcdm_sram u_sram (
    .clk_i, .rst_ni,
    .tcdm (mem_bus.slave),
    .wr_en_i, .wr_addr_i, .wr_data_i
  );

endmodule

// ==== hw/tcdm_if.sv ====
// ##########################################################################
// tcdm memory port
// request/grant with a one-cycle read response, no back-pressure on
// the response side
// ##########################################################################

`timescale 1ns/1ps

interface tcdm_if
  import stream_src_pkg::*;
;

  logic              req;
  logic [ADDR_W-1:0] add;      // byte address
  logic              gnt;      // same cycle as req
  logic [DATA_W-1:0] r_data;
  logic              r_valid;  // one cycle after a taken req

  modport master (
    output req, add,
    input  gnt, r_data, r_valid
  );

  modport slave (
    input  req, add,
    output gnt, r_data, r_valid
  );

endinterface

// ==== hw/tcdm_sram.sv ====
// ##########################################################################
// tcdm scratchpad
// single-port word memory, one-cycle read latency, the external
// write port wins over reads
// ##########################################################################

`timescale 1ns/1ps

module tcdm_sram
  import stream_src_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  tcdm_if.slave             tcdm,
  input  logic              wr_en_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic [DATA_W-1:0] wr_data_i
);

  logic [DATA_W-1:0] mem_q [MEM_WORDS];
  logic [MEM_AW-1:0] rd_idx;
  logic [MEM_AW-1:0] wr_idx;
  logic              rd_take;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;

  // byte addresses, low two bits dropped
  assign rd_idx = tcdm.add[MEM_AW+1:2];
  assign wr_idx = wr_addr_i[MEM_AW+1:2];

  assign tcdm.gnt = !wr_en_i;  // writes stall reads
  assign rd_take  = tcdm.req && tcdm.gnt;

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_idx] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_take) begin
      rdata_q <= mem_q[rd_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_take;
    end
  end

  assign tcdm.r_data  = rdata_q;
  assign tcdm.r_valid = rvalid_q;

endmodule

// ==== list.f ====
hw/stream_src_pkg.sv
hw/tcdm_if.sv
hw/src_ctrl_fsm.sv
hw/src_addr_gen.sv
hw/src_resp_buffer.sv
hw/tcdm_sram.sv
hw/stream_src_top.sv
sim/stream_src_assert.sv
sim/stream_src_tb.sv

// ==== sim/stream_src_assert.sv ====
// ##########################################################################
// stream source protocol assertions
// output stream hold, done pulse shape and request gating
// ##########################################################################

`timescale 1ns/1ps

module stream_src_assert
  import stream_src_pkg::*;
(
  input logic              clk_i,
  input logic              rst_ni,
  input logic              clear_i,
  input logic              out_ready_i,
  input logic              out_valid_i,
  input logic [DATA_W-1:0] out_data_i,
  input logic              done_i,
  input logic              ready_start_i,
  input logic              req_i,
  input logic              r_valid_i,
  input src_state_e        state_i
);

  // a clear may drop the stalled beat
  hold_under_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_i && !out_ready_i && !clear_i |=> out_valid_i && $stable(out_data_i))
    else $error("stream beat changed under back-pressure");

  done_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
    else $error("done lasted more than one cycle");

  // ready only once the pulse is over
  done_then_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> !ready_start_i ##1 ready_start_i)
    else $error("ready_start wrong around the done pulse");

  no_req_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i == SRC_IDLE |-> !req_i && !r_valid_i)
    else $error("memory request or response while idle");

endmodule

bind stream_src_top stream_src_assert u_assert (
  .clk_i,
  .rst_ni,
  .clear_i,
  .out_ready_i,
  .out_valid_i   (out_valid_o),
  .out_data_i    (out_data_o),
  .done_i        (done_o),
  .ready_start_i (ready_start_o),
  .req_i         (mem_bus.req),
  .r_valid_i     (mem_bus.r_valid),
  .state_i       (u_fsm.state_q)
);

// ==== sim/stream_src_tb.sv ====
// ##########################################################################
// stream source testbench
// directed transfers against a mirrored copy of the scratchpad, covering
// back-pressure, write stalls, single beats and clear
// ##########################################################################

`timescale 1ns/1ps

module stream_src_tb
  import stream_src_pkg::*;
;

  localparam int unsigned TOTAL_BEATS     = 242;
  localparam int unsigned WATCHDOG_CYCLES = TOTAL_BEATS * 20 + MEM_WORDS + 1000;

  logic              clk_i;
  logic              rst_ni;
  logic              clear_i;
  logic              start_i;
  logic [ADDR_W-1:0] base_addr_i;
  logic [CNT_W-1:0]  stride_i;
  logic [CNT_W-1:0]  trans_size_i;
  logic              wr_en_i;
  logic [ADDR_W-1:0] wr_addr_i;
  logic [DATA_W-1:0] wr_data_i;
  logic              out_ready_i;
  logic              ready_start_o;
  logic              done_o;
  logic              out_valid_o;
  logic [DATA_W-1:0] out_data_o;

  logic [DATA_W-1:0] ref_mem [MEM_WORDS];  // mirror of every write
  logic [DATA_W-1:0] beats [$];
  int unsigned       done_cnt = 0;
  int unsigned       beats_at_done = 0;  // beats seen before the done cycle
  integer            seed;

  stream_src_top u_dut (.*);

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // sampled mid-cycle while outputs are stable
  always @(negedge clk_i) begin
    if (rst_ni && done_o) begin
      done_cnt++;
      beats_at_done = beats.size();
    end
    if (rst_ni && out_valid_o && out_ready_i) begin
      beats.push_back(out_data_o);
    end
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "run aborted");
  endtask

  task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    wr_en_i   = 1'b1;
    wr_addr_i = addr;
    wr_data_i = data;
    ref_mem[addr[MEM_AW+1:2]] = data;
    next_cycle();
    wr_en_i = 1'b0;
  endtask

  task automatic preload_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      write_word(ADDR_W'(i * 4), $random(seed));
    end
  endtask

  // beat k sits at base + k * stride modulo 4 KiB
  function automatic logic [DATA_W-1:0] expected_beat(input logic [ADDR_W-1:0] base,
                                                      input logic [CNT_W-1:0] stride,
                                                      input int unsigned k);
    int unsigned       addr;
    logic [MEM_AW-1:0] idx;
    addr = (32'(base) + k * 32'(stride)) % 4096;
    idx  = MEM_AW'(addr / 4);
    return ref_mem[idx];
  endfunction

  task automatic start_transfer(input logic [ADDR_W-1:0] base, input logic [CNT_W-1:0] stride,
                                input logic [CNT_W-1:0] size);
    while (!ready_start_o) begin
      next_cycle();
    end
    start_i      = 1'b1;
    base_addr_i  = base;
    stride_i     = stride;
    trans_size_i = size;
    next_cycle();
    start_i = 1'b0;
    check_val("ready_start_o", 32'(ready_start_o), 32'h0);  // busy now
  endtask

  task automatic drive_cycle(input bit rdy_rand, input bit wr_rand);
    logic [31:0] rnd;
    rnd         = $random(seed);
    out_ready_i = rdy_rand ? (rnd[0] | rnd[1]) : 1'b1;
    wr_en_i     = wr_rand & rnd[2];
    wr_addr_i   = {4'h8, rnd[9:4], 2'b00};  // 0x800..0x8ff only
    wr_data_i   = $random(seed);
    if (wr_en_i) begin
      ref_mem[wr_addr_i[MEM_AW+1:2]] = wr_data_i;
    end
    next_cycle();
  endtask

  task automatic run_transfer(input logic [ADDR_W-1:0] base, input logic [CNT_W-1:0] stride,
                              input logic [CNT_W-1:0] size, input bit rdy_rand,
                              input bit wr_rand);
    int unsigned done_before;
    done_before = done_cnt;
    beats.delete();
    start_transfer(base, stride, size);
    while (done_cnt == done_before) begin
      check_val("ready_start_o", 32'(ready_start_o), 32'h0);
      drive_cycle(rdy_rand, wr_rand);
    end
    out_ready_i = 1'b1;
    wr_en_i     = 1'b0;
    check_val("ready_start_o", 32'(ready_start_o), 32'h1);
    next_cycle();
    check_val("done_o pulses", done_cnt - done_before, 32'h1);
    if (beats_at_done != int'(size)) begin
      abort_run($sformatf("done_o came after %0d of %0d beats", beats_at_done, size));
    end
    if (beats.size() != int'(size)) begin
      abort_run($sformatf("expected %0d beats but the stream gave %0d", size, beats.size()));
    end
    for (int k = 0; k < int'(size); k++) begin
      check_val($sformatf("out_data_o beat %0d", k), beats[k], expected_beat(base, stride, k));
    end
  endtask

  task automatic contiguous_read();
    run_transfer(12'h100, 16'd4, 16'd16, 1'b0, 1'b0);
  endtask

  task automatic strided_wrap_read();
    run_transfer(12'hffa, 16'd12, 16'd16, 1'b0, 1'b0);  // crosses 4096
  endtask

  task automatic backpressure_read();
    run_transfer(12'h200, 16'd4, 16'd32, 1'b1, 1'b0);
  endtask

  task automatic write_contention();
    run_transfer(12'h000, 16'd8, 16'd32, 1'b1, 1'b1);
    run_transfer(12'h800, 16'd4, 16'd64, 1'b0, 1'b0);  // read the written words back
  endtask

  task automatic single_beat_restart();
    run_transfer(12'h3f0, 16'd4, 16'd1, 1'b0, 1'b0);
    run_transfer(12'h124, 16'd4, 16'd1, 1'b1, 1'b0);
  endtask

  task automatic clear_mid_transfer();
    start_transfer(12'h400, 16'd4, 16'd64);
    repeat (20) drive_cycle(1'b1, 1'b0);
    clear_i = 1'b1;
    next_cycle();
    clear_i     = 1'b0;
    out_ready_i = 1'b1;
    check_val("ready_start_o", 32'(ready_start_o), 32'h1);
    check_val("out_valid_o", 32'(out_valid_o), 32'h0);
    run_transfer(12'h400, 16'd4, 16'd16, 1'b1, 1'b0);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    abort_run("watchdog timeout, a transfer never finished");
  end

  initial begin
    seed         = 24800;
    rst_ni       = 1'b0;
    clear_i      = 1'b0;
    start_i      = 1'b0;
    base_addr_i  = '0;
    stride_i     = '0;
    trans_size_i = '0;
    wr_en_i      = 1'b0;
    wr_addr_i    = '0;
    wr_data_i    = '0;
    out_ready_i  = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_val("ready_start_o", 32'(ready_start_o), 32'h1);
    check_val("out_valid_o", 32'(out_valid_o), 32'h0);
    check_val("done_o", 32'(done_o), 32'h0);
    preload_memory();
    contiguous_read();
    strided_wrap_read();
    backpressure_read();
    write_contention();
    single_beat_restart();
    clear_mid_transfer();
    $display("Test passed");
    $finish;
  end

endmodule
